// ==== source/snes_bus_pkg.sv ====
`default_nettype none

package snes_bus_pkg;

  // Console bus widths
  typedef logic [23:0] snes_addr_t;
  typedef logic [7:0]  snes_data_t;

  // Command window page and offset inside it
  typedef logic [14:0] cmd_page_t;
  typedef logic [8:0]  cmd_ofs_t;

  //////////////////////////////////////////////////
  // Interrupt vectors in bank 00
  localparam snes_addr_t NMI_VEC_LO = 24'h00FFEA;
  localparam snes_addr_t NMI_VEC_HI = 24'h00FFEB;
  localparam snes_addr_t IRQ_VEC_LO = 24'h00FFEE;
  localparam snes_addr_t IRQ_VEC_HI = 24'h00FFEF;

  // Vector bytes handed out while hooked
  localparam snes_data_t HOOK_DATA_NMI_HI = 8'hE0;
  localparam snes_data_t HOOK_DATA_IRQ_HI = 8'hE6;
  localparam snes_data_t HOOK_DATA_LO     = 8'h2B;

  //////////////////////////////////////////////////
  // 512 byte window at 002A00
  localparam cmd_page_t CMD_BASE             = 15'h0015;
  localparam cmd_ofs_t  CMD_CODE_OFS         = 9'h000;
  localparam cmd_ofs_t  CMD_HOOK_DISABLE_OFS = 9'h1FD;

  localparam snes_data_t CMD_PATCH_ON   = 8'h82;
  localparam snes_data_t CMD_PATCH_OFF  = 8'h83;
  localparam snes_data_t CMD_HOOK_OFF   = 8'h84;
  localparam snes_data_t CMD_HOOK_DELAY = 8'h85;

endpackage

`default_nettype wire

// ==== source/patch_pkg.sv ====
`default_nettype none

package patch_pkg;

  // Number of address/data patch entries
  localparam int NUM_PATCHES = 6;

  // Host program word with the address on top and the data byte below
  typedef logic [31:0] pgm_word_t;
  typedef logic [2:0]  patch_idx_t;

  typedef logic [NUM_PATCHES-1:0] patch_mask_t;

  // Global flags in the order irq, nmi, patch
  typedef logic [2:0] patch_flags_t;

  //////////////////////////////////////////////////
  // Slots above the patch entries
  localparam patch_idx_t PGM_SLOT_MASK  = 3'd6;
  localparam patch_idx_t PGM_SLOT_FLAGS = 3'd7;

  // Field positions inside a program word
  localparam int PGM_ADDR_LSB     = 8;
  localparam int PGM_FLAG_CLR_LSB = 4;
  localparam int PGM_FLAG_SET_LSB = 0;

endpackage

`default_nettype wire

// ==== source/bus_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sync (
  input  wire                             clk,
  input  wire                             rst,
  input  wire snes_bus_pkg::snes_addr_t   snes_addr,
  input  wire snes_bus_pkg::snes_data_t   snes_data,
  input  wire                             snes_rd_n,
  input  wire                             snes_wr_n,
  output snes_bus_pkg::snes_addr_t        bus_addr,
  output snes_bus_pkg::snes_data_t        bus_wdata,
  output logic                            cycle_start,
  output logic                            cmd_wr_strobe
);

  snes_bus_pkg::snes_addr_t addr_s1;
  snes_bus_pkg::snes_addr_t addr_s2;
  snes_bus_pkg::snes_data_t data_s1;
  snes_bus_pkg::snes_data_t data_s2;

  // Two sync stages plus one history stage per strobe
  logic [2:0] rd_n_sync;
  logic [2:0] wr_n_sync;
  logic       rd_fall;
  logic       wr_fall;
  logic       wr_rise;
  logic       in_window;

  assign rd_fall   = rd_n_sync[2] & ~rd_n_sync[1];
  assign wr_fall   = wr_n_sync[2] & ~wr_n_sync[1];
  assign wr_rise   = ~wr_n_sync[2] & wr_n_sync[1];
  assign in_window = (addr_s2[23:9] == snes_bus_pkg::CMD_BASE);

  // Address and data pipeline lined up with the strobe pulses
  always_ff @(posedge clk) begin
    addr_s1   <= snes_addr;
    addr_s2   <= addr_s1;
    bus_addr  <= addr_s2;
    data_s1   <= snes_data;
    data_s2   <= data_s1;
    bus_wdata <= data_s2;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_n_sync     <= '1;
      wr_n_sync     <= '1;
      cycle_start   <= 1'b0;
      cmd_wr_strobe <= 1'b0;
    end else begin
      rd_n_sync     <= {rd_n_sync[1:0], snes_rd_n};
      wr_n_sync     <= {wr_n_sync[1:0], snes_wr_n};
      cycle_start   <= rd_fall | wr_fall;
      // Write data is taken at the end of the write strobe
      cmd_wr_strobe <= wr_rise & in_window;
    end
  end

endmodule

`default_nettype wire

// ==== source/patch_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module patch_table (
  input  wire                            clk,
  input  wire                            rst,
  input  wire snes_bus_pkg::snes_addr_t  bus_addr,
  input  wire snes_bus_pkg::snes_data_t  bus_wdata,
  input  wire                            cmd_wr_strobe,
  input  wire                            pgm_valid,
  input  wire patch_pkg::patch_idx_t     pgm_idx,
  input  wire patch_pkg::pgm_word_t      pgm_word,
  input  wire                            hook_hit,
  input  wire snes_bus_pkg::snes_data_t  hook_data,
  output logic                           pgm_ready,
  output logic                           nmi_enable,
  output logic                           irq_enable,
  output logic                           hook_delay_start,
  output logic                           hook_disable,
  output snes_bus_pkg::snes_data_t       bus_data,
  output logic                           bus_override
);

  snes_bus_pkg::snes_addr_t   patch_addr [patch_pkg::NUM_PATCHES];
  snes_bus_pkg::snes_data_t   patch_data [patch_pkg::NUM_PATCHES];
  patch_pkg::patch_mask_t     enable_mask;
  patch_pkg::patch_mask_t     match;
  patch_pkg::patch_flags_t    flags_clr;
  patch_pkg::patch_flags_t    flags_set;
  snes_bus_pkg::cmd_ofs_t     cmd_ofs;
  logic                       patch_enable;
  logic                       pgm_accept;
  logic                       cmd_code_wr;

  // Console commands win over the host port
  assign pgm_ready   = ~cmd_wr_strobe;
  assign pgm_accept  = pgm_valid & pgm_ready;
  assign cmd_ofs     = bus_addr[8:0];
  assign cmd_code_wr = cmd_wr_strobe & (cmd_ofs == snes_bus_pkg::CMD_CODE_OFS);
  assign flags_clr   = pgm_word[patch_pkg::PGM_FLAG_CLR_LSB +: $bits(flags_clr)];
  assign flags_set   = pgm_word[patch_pkg::PGM_FLAG_SET_LSB +: $bits(flags_set)];

  //////////////////////////////////////////////////
  // Patch entries
  always_ff @(posedge clk) begin
    if (pgm_accept && (pgm_idx < patch_pkg::NUM_PATCHES)) begin
      patch_addr[pgm_idx] <= pgm_word[31:patch_pkg::PGM_ADDR_LSB];
      patch_data[pgm_idx] <= pgm_word[patch_pkg::PGM_ADDR_LSB-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Command and flag decode
  always_ff @(posedge clk) begin
    if (rst) begin
      enable_mask      <= '0;
      patch_enable     <= 1'b0;
      nmi_enable       <= 1'b0;
      irq_enable       <= 1'b0;
      hook_disable     <= 1'b0;
      hook_delay_start <= 1'b0;
    end else begin
      hook_delay_start <= 1'b0;
      if (cmd_code_wr) begin
        case (bus_wdata)
          snes_bus_pkg::CMD_PATCH_ON:   patch_enable <= 1'b1;
          snes_bus_pkg::CMD_PATCH_OFF:  patch_enable <= 1'b0;
          snes_bus_pkg::CMD_HOOK_OFF: begin
            nmi_enable <= 1'b0;
            irq_enable <= 1'b0;
          end
          snes_bus_pkg::CMD_HOOK_DELAY: hook_delay_start <= 1'b1;
          default: ;
        endcase
      end else if (cmd_wr_strobe && (cmd_ofs == snes_bus_pkg::CMD_HOOK_DISABLE_OFS)) begin
        hook_disable <= bus_wdata[0];
      end else if (pgm_accept) begin
        if (pgm_idx == patch_pkg::PGM_SLOT_MASK) begin
          enable_mask <= pgm_word[patch_pkg::NUM_PATCHES-1:0];
        end else if (pgm_idx == patch_pkg::PGM_SLOT_FLAGS) begin
          // Clear first, then set
          {irq_enable, nmi_enable, patch_enable} <=
            ({irq_enable, nmi_enable, patch_enable} & ~flags_clr) | flags_set;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < patch_pkg::NUM_PATCHES; i++) begin
      match[i] = enable_mask[i] & (bus_addr == patch_addr[i]);
    end
  end

  // Lowest matching slot supplies the byte
  always_comb begin
    bus_data = hook_data;
    for (int i = patch_pkg::NUM_PATCHES - 1; i >= 0; i--) begin
      if (match[i]) begin
        bus_data = patch_data[i];
      end
    end
  end

  assign bus_override = (patch_enable & (|match)) | hook_hit;

endmodule

`default_nettype wire

// ==== source/hook_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hook_ctrl #(
  parameter int USAGE_BITS        = 21,
  parameter int HOOK_DELAY_CYCLES = 880000000
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire snes_bus_pkg::snes_addr_t  bus_addr,
  input  wire                            cycle_start,
  input  wire                            nmi_enable,
  input  wire                            irq_enable,
  input  wire                            hook_delay_start,
  input  wire                            hook_disable,
  output logic                           hook_hit,
  output snes_bus_pkg::snes_data_t       hook_data
);

  localparam int TIMER_BITS = $clog2(HOOK_DELAY_CYCLES + 1);

  typedef logic [USAGE_BITS-1:0] usage_period_t;
  typedef logic [TIMER_BITS-1:0] delay_count_t;
  typedef logic [4:0]            usage_cnt_t;
  typedef enum logic {HOOK_SEL_NMI, HOOK_SEL_IRQ} hook_sel_e;

  logic          nmi_lo;
  logic          nmi_hi;
  logic          irq_lo;
  logic          irq_hi;
  logic          vec_access;
  logic          period_end;
  logic          count_nmi;
  logic          count_irq;
  usage_period_t usage_count;
  usage_cnt_t    nmi_usage;
  usage_cnt_t    irq_usage;
  hook_sel_e     hook_sel;
  hook_sel_e     hook_sel_sync;
  delay_count_t  delay_count;
  logic          hook_enable;
  logic          hook_enable_sync;
  logic [1:0]    sync_delay;

  assign nmi_lo     = (bus_addr == snes_bus_pkg::NMI_VEC_LO);
  assign nmi_hi     = (bus_addr == snes_bus_pkg::NMI_VEC_HI);
  assign irq_lo     = (bus_addr == snes_bus_pkg::IRQ_VEC_LO);
  assign irq_hi     = (bus_addr == snes_bus_pkg::IRQ_VEC_HI);
  assign vec_access = nmi_lo | nmi_hi | irq_lo | irq_hi;

  //////////////////////////////////////////////////
  // Vector usage over one period
  assign period_end = (usage_count == '0);
  assign count_nmi  = cycle_start & nmi_lo & ~hook_disable;
  assign count_irq  = cycle_start & irq_lo & ~hook_disable;

  always_ff @(posedge clk) begin
    if (rst) begin
      usage_count <= '1;
      nmi_usage   <= '0;
      irq_usage   <= '0;
      hook_sel    <= HOOK_SEL_NMI;
    end else begin
      usage_count <= usage_count - 1'b1;
      if (period_end) begin
        nmi_usage <= usage_cnt_t'(count_nmi);
        irq_usage <= usage_cnt_t'(count_irq);
        // IRQ only when the game never read the NMI vector
        if ((irq_usage != '0) && (nmi_usage == '0)) begin
          hook_sel <= HOOK_SEL_IRQ;
        end else begin
          hook_sel <= HOOK_SEL_NMI;
        end
      end else begin
        if (count_nmi && (nmi_usage != '1)) nmi_usage <= nmi_usage + 1'b1;
        if (count_irq && (irq_usage != '1)) irq_usage <= irq_usage + 1'b1;
      end
    end
  end

  // Hook delay countdown
  always_ff @(posedge clk) begin
    if (rst) begin
      delay_count <= '0;
    end else if (hook_delay_start) begin
      delay_count <= delay_count_t'(HOOK_DELAY_CYCLES);
    end else if (delay_count != '0) begin
      delay_count <= delay_count - 1'b1;
    end
  end

  assign hook_enable = (delay_count == '0) & ~hook_disable;

  //////////////////////////////////////////////////
  // Never switch vectors in the middle of a vector fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_delay       <= 2'd2;
      hook_sel_sync    <= HOOK_SEL_NMI;
      hook_enable_sync <= 1'b0;
    end else if (cycle_start) begin
      if (vec_access) begin
        sync_delay <= 2'd2;
      end else if (sync_delay != 2'd0) begin
        sync_delay <= sync_delay - 1'b1;
      end else begin
        hook_sel_sync    <= hook_sel;
        hook_enable_sync <= hook_enable;
      end
    end
  end

  assign hook_hit = hook_enable_sync &
                    (((hook_sel_sync == HOOK_SEL_NMI) & nmi_enable & (nmi_lo | nmi_hi)) |
                     ((hook_sel_sync == HOOK_SEL_IRQ) & irq_enable & (irq_lo | irq_hi)));

  always_comb begin
    if (nmi_hi) begin
      hook_data = snes_bus_pkg::HOOK_DATA_NMI_HI;
    end else if (irq_hi) begin
      hook_data = snes_bus_pkg::HOOK_DATA_IRQ_HI;
    end else begin
      hook_data = snes_bus_pkg::HOOK_DATA_LO;
    end
  end

endmodule

`default_nettype wire

// ==== source/snes_patch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_patch_top #(
  parameter int USAGE_BITS        = 21,
  parameter int HOOK_DELAY_CYCLES = 880000000
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire snes_bus_pkg::snes_addr_t  snes_addr,
  input  wire snes_bus_pkg::snes_data_t  snes_data,
  input  wire                            snes_rd_n,
  input  wire                            snes_wr_n,
  input  wire                            pgm_valid,
  input  wire patch_pkg::patch_idx_t     pgm_idx,
  input  wire patch_pkg::pgm_word_t      pgm_word,
  output logic                           pgm_ready,
  output snes_bus_pkg::snes_data_t       bus_data,
  output logic                           bus_override
);

  snes_bus_pkg::snes_addr_t bus_addr;
  snes_bus_pkg::snes_data_t bus_wdata;
  snes_bus_pkg::snes_data_t hook_data;
  logic                     cycle_start;
  logic                     cmd_wr_strobe;
  logic                     nmi_enable;
  logic                     irq_enable;
  logic                     hook_delay_start;
  logic                     hook_disable;
  logic                     hook_hit;

  // Console strobes into the clock domain
  bus_sync u_bus_sync (
    .clk           (clk),
    .rst           (rst),
    .snes_addr     (snes_addr),
    .snes_data     (snes_data),
    .snes_rd_n     (snes_rd_n),
    .snes_wr_n     (snes_wr_n),
    .bus_addr      (bus_addr),
    .bus_wdata     (bus_wdata),
    .cycle_start   (cycle_start),
    .cmd_wr_strobe (cmd_wr_strobe)
  );

  patch_table u_patch_table (
    .clk              (clk),
    .rst              (rst),
    .bus_addr         (bus_addr),
    .bus_wdata        (bus_wdata),
    .cmd_wr_strobe    (cmd_wr_strobe),
    .pgm_valid        (pgm_valid),
    .pgm_idx          (pgm_idx),
    .pgm_word         (pgm_word),
    .hook_hit         (hook_hit),
    .hook_data        (hook_data),
    .pgm_ready        (pgm_ready),
    .nmi_enable       (nmi_enable),
    .irq_enable       (irq_enable),
    .hook_delay_start (hook_delay_start),
    .hook_disable     (hook_disable),
    .bus_data         (bus_data),
    .bus_override     (bus_override)
  );

  hook_ctrl #(
    .USAGE_BITS        (USAGE_BITS),
    .HOOK_DELAY_CYCLES (HOOK_DELAY_CYCLES)
  ) u_hook_ctrl (
    .clk              (clk),
    .rst              (rst),
    .bus_addr         (bus_addr),
    .cycle_start      (cycle_start),
    .nmi_enable       (nmi_enable),
    .irq_enable       (irq_enable),
    .hook_delay_start (hook_delay_start),
    .hook_disable     (hook_disable),
    .hook_hit         (hook_hit),
    .hook_data        (hook_data)
  );

endmodule

`default_nettype wire

// ==== tb/patch_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module patch_monitor (
  input  wire        clk,
  input  wire        check_en,
  input  wire [23:0] check_addr,
  input  wire [7:0]  exp_data,
  input  wire        exp_ovr,
  input  wire [7:0]  bus_data,
  input  wire        bus_override,
  input  wire        ready_chk_en,
  input  wire        exp_ready,
  input  wire        pgm_ready,
  input  wire        test_done,
  input  wire [3:0]  test_num,
  output int         error_count,
  output int         check_count,
  output int         fail_tests
);

  int test_errors;
  int test_checks;

  initial begin
    error_count = 0;
    check_count = 0;
    fail_tests  = 0;
    test_errors = 0;
    test_checks = 0;
  end

  //////////////////////////////////////////////////
  // Compare on the sample edge while the address is held
  always @(posedge clk) begin
    if (check_en) begin
      check_count++;
      test_checks++;
      if (bus_override !== exp_ovr) begin
        $display("Error: bus_override at addr %h: got %h, expected %h",
                 check_addr, bus_override, exp_ovr);
        error_count++;
        test_errors++;
      end else if (exp_ovr && (bus_data !== exp_data)) begin
        $display("Error: bus_data at addr %h: got %h, expected %h",
                 check_addr, bus_data, exp_data);
        error_count++;
        test_errors++;
      end
    end
    if (ready_chk_en) begin
      check_count++;
      test_checks++;
      if (pgm_ready !== exp_ready) begin
        $display("Error: pgm_ready: got %h, expected %h", pgm_ready, exp_ready);
        error_count++;
        test_errors++;
      end
    end
    if (test_done) begin
      if (test_errors == 0) begin
        $display("Test %0d passed (%0d checks)", test_num, test_checks);
      end else begin
        $display("Test %0d FAILED (%0d of %0d checks wrong)", test_num, test_errors, test_checks);
        fail_tests++;
      end
      test_errors = 0;
      test_checks = 0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/snes_patch_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_patch_chk (
  input wire        clk,
  input wire        rst,
  input wire        pgm_valid,
  input wire        pgm_ready,
  input wire [31:0] pgm_word,
  input wire        cycle_start,
  input wire        cmd_wr_strobe,
  input wire        bus_override
);

  // Host holds its word while stalled
  a_word_stable: assert property (@(posedge clk) disable iff (rst)
    (pgm_valid && !pgm_ready) |=> $stable(pgm_word))
    else $error("pgm_word changed while stalled");

  a_cycle_pulse: assert property (@(posedge clk) disable iff (rst)
    cycle_start |=> !cycle_start)
    else $error("cycle_start longer than one cycle");

  a_cmd_pulse: assert property (@(posedge clk) disable iff (rst)
    cmd_wr_strobe |=> !cmd_wr_strobe)
    else $error("cmd_wr_strobe longer than one cycle");

  a_reset_override: assert property (@(posedge clk) rst |=> !bus_override)
    else $error("bus_override set after reset");

endmodule

bind snes_patch_top snes_patch_chk u_chk (
  .clk (clk), .rst (rst), .pgm_valid (pgm_valid), .pgm_ready (pgm_ready),
  .pgm_word (pgm_word), .cycle_start (cycle_start), .cmd_wr_strobe (cmd_wr_strobe),
  .bus_override (bus_override)
);

`default_nettype wire

// ==== tb/snes_patch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_patch_tb;

  typedef enum logic [2:0] {
    OP_PGM, OP_CMD, OP_READ, OP_PEEK, OP_IDLE, OP_CMD_PGM, OP_DONE
  } op_e;

  // One table row
  // OP_CMD_PGM uses addr and data for the command and idx and word for the host
  typedef struct packed {
    op_e                      op;
    patch_pkg::patch_idx_t    idx;
    snes_bus_pkg::snes_addr_t addr;
    patch_pkg::pgm_word_t     word;
    snes_bus_pkg::snes_data_t data;
    logic                     ovr;
    logic [15:0]              n;
  } step_t;

  logic                     clk;
  logic                     rst;
  snes_bus_pkg::snes_addr_t snes_addr;
  snes_bus_pkg::snes_data_t snes_data;
  logic                     snes_rd_n;
  logic                     snes_wr_n;
  logic                     pgm_valid;
  patch_pkg::patch_idx_t    pgm_idx;
  patch_pkg::pgm_word_t     pgm_word;
  logic                     pgm_ready;
  snes_bus_pkg::snes_data_t bus_data;
  logic                     bus_override;
  logic                     check_en;
  snes_bus_pkg::snes_data_t exp_data;
  logic                     exp_ovr;
  logic                     ready_chk_en;
  logic                     exp_ready;
  logic                     test_done;
  logic [3:0]               test_num;
  int                       error_count;
  int                       check_count;
  int                       fail_tests;
  int                       seed;
  logic                     table_ready;
  step_t                    steps[$];

  snes_patch_top #(
    .USAGE_BITS        (10),
    .HOOK_DELAY_CYCLES (200)
  ) dut (
    .clk (clk), .rst (rst),
    .snes_addr (snes_addr), .snes_data (snes_data),
    .snes_rd_n (snes_rd_n), .snes_wr_n (snes_wr_n),
    .pgm_valid (pgm_valid), .pgm_idx (pgm_idx), .pgm_word (pgm_word),
    .pgm_ready (pgm_ready), .bus_data (bus_data), .bus_override (bus_override)
  );

  patch_monitor u_monitor (
    .clk (clk), .check_en (check_en), .check_addr (snes_addr),
    .exp_data (exp_data), .exp_ovr (exp_ovr),
    .bus_data (bus_data), .bus_override (bus_override),
    .ready_chk_en (ready_chk_en), .exp_ready (exp_ready), .pgm_ready (pgm_ready),
    .test_done (test_done), .test_num (test_num),
    .error_count (error_count), .check_count (check_count), .fail_tests (fail_tests)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic void add_step(op_e op, patch_pkg::patch_idx_t idx,
                                   snes_bus_pkg::snes_addr_t addr,
                                   patch_pkg::pgm_word_t word, snes_bus_pkg::snes_data_t data,
                                   logic ovr, int n);
    step_t s;
    s = '{op: op, idx: idx, addr: addr, word: word, data: data, ovr: ovr, n: n[15:0]};
    steps.push_back(s);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Console and host bus tasks
  task automatic bus_read(snes_bus_pkg::snes_addr_t addr, logic chk,
                          snes_bus_pkg::snes_data_t d, logic o);
    snes_addr = addr;
    snes_rd_n = 1'b0;
    repeat (4) next_cycle();
    // Monitor samples on the 5th edge
    check_en = chk;
    exp_data = d;
    exp_ovr  = o;
    next_cycle();
    check_en = 1'b0;
    next_cycle();
    snes_rd_n = 1'b1;
    repeat (3) next_cycle();
  endtask

  task automatic cmd_write(snes_bus_pkg::snes_addr_t addr, snes_bus_pkg::snes_data_t d);
    snes_addr = addr;
    snes_data = d;
    snes_wr_n = 1'b0;
    repeat (4) next_cycle();
    snes_wr_n = 1'b1;
    repeat (6) next_cycle();
  endtask

  task automatic host_program(patch_pkg::patch_idx_t idx, patch_pkg::pgm_word_t word);
    logic taken;
    pgm_valid = 1'b1;
    pgm_idx   = idx;
    pgm_word  = word;
    do begin
      @(negedge clk);
      taken = pgm_ready;
      next_cycle();
    end while (!taken);
    pgm_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  task automatic build_table();
    snes_bus_pkg::snes_addr_t a[6];
    snes_bus_pkg::snes_data_t d[6];
    snes_bus_pkg::snes_addr_t a_new;
    snes_bus_pkg::snes_data_t d_new;
    int r;
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      a[i] = {8'hC0 + 8'(i), r[15:0]};
      d[i] = r[23:16];
    end
    r = $random(seed);
    a_new = {8'hD3, r[15:0]};
    d_new = r[23:16];

    // Test 1 reads every slot with slot 5 masked off
    for (int i = 0; i < 6; i++) add_step(OP_PGM, 3'(i), 0, {a[i], d[i]}, 0, 0, 0);
    add_step(OP_PGM, patch_pkg::PGM_SLOT_MASK, 0, 32'h0000_001F, 0, 0, 0);
    add_step(OP_PGM, patch_pkg::PGM_SLOT_FLAGS, 0, 32'h0000_0001, 0, 0, 0);
    for (int i = 0; i < 5; i++) add_step(OP_READ, 0, a[i], 0, d[i], 1'b1, 0);
    add_step(OP_READ, 0, a[5], 0, 0, 1'b0, 0);
    add_step(OP_READ, 0, 24'h123456, 0, 0, 1'b0, 0);
    add_step(OP_DONE, 0, 0, 0, 0, 0, 1);

    // Test 2 lets slot 4 shadow slot 1 so the lower index wins
    add_step(OP_PGM, 3'd4, 0, {a[1], ~d[1]}, 0, 0, 0);
    add_step(OP_READ, 0, a[1], 0, d[1], 1'b1, 0);
    add_step(OP_CMD, 0, 24'h002A00, 0, snes_bus_pkg::CMD_PATCH_OFF, 0, 0);
    add_step(OP_READ, 0, a[1], 0, 0, 1'b0, 0);
    add_step(OP_PGM, patch_pkg::PGM_SLOT_FLAGS, 0, 32'h0000_0001, 0, 0, 0);
    add_step(OP_READ, 0, a[1], 0, d[1], 1'b1, 0);
    add_step(OP_DONE, 0, 0, 0, 0, 0, 2);

    // Test 3 offers a host word while a command strobe is in flight
    add_step(OP_CMD_PGM, 3'd3, 24'h002A00, {a_new, d_new}, snes_bus_pkg::CMD_PATCH_ON, 0, 0);
    add_step(OP_READ, 0, a_new, 0, d_new, 1'b1, 0);
    add_step(OP_READ, 0, a[3], 0, 0, 1'b0, 0);
    add_step(OP_DONE, 0, 0, 0, 0, 0, 3);

    // Test 4 takes the NMI hook and then blocks it by the delay timer
    add_step(OP_PGM, patch_pkg::PGM_SLOT_FLAGS, 0, 32'h0000_0002, 0, 0, 0);
    for (int i = 0; i < 3; i++) add_step(OP_READ, 0, 24'h008000 + i, 0, 0, 1'b0, 0);
    add_step(OP_READ, 0, 24'h00FFEB, 0, 8'hE0, 1'b1, 0);
    add_step(OP_READ, 0, 24'h00FFEA, 0, 8'h2B, 1'b1, 0);
    add_step(OP_CMD, 0, 24'h002A00, 0, snes_bus_pkg::CMD_HOOK_DELAY, 0, 0);
    for (int i = 0; i < 3; i++) add_step(OP_READ, 0, 24'h008010 + i, 0, 0, 1'b0, 0);
    add_step(OP_READ, 0, 24'h00FFEB, 0, 0, 1'b0, 0);
    add_step(OP_IDLE, 0, 0, 0, 0, 0, 400);
    for (int i = 0; i < 3; i++) add_step(OP_READ, 0, 24'h008020 + i, 0, 0, 1'b0, 0);
    add_step(OP_READ, 0, 24'h00FFEB, 0, 8'hE0, 1'b1, 0);
    add_step(OP_DONE, 0, 0, 0, 0, 0, 4);

    // Test 5 makes only IRQ vector reads over more than two usage periods
    add_step(OP_PGM, patch_pkg::PGM_SLOT_FLAGS, 0, 32'h0000_0004, 0, 0, 0);
    for (int i = 0; i < 250; i++) add_step(OP_PEEK, 0, 24'h00FFEE, 0, 0, 0, 0);
    for (int i = 0; i < 3; i++) add_step(OP_READ, 0, 24'h008030 + i, 0, 0, 1'b0, 0);
    add_step(OP_READ, 0, 24'h00FFEF, 0, 8'hE6, 1'b1, 0);
    add_step(OP_READ, 0, 24'h00FFEB, 0, 0, 1'b0, 0);
    add_step(OP_DONE, 0, 0, 0, 0, 0, 5);

    // Test 6 sets hook_disable through window offset 1FD
    add_step(OP_CMD, 0, 24'h002BFD, 0, 8'h01, 0, 0);
    for (int i = 0; i < 3; i++) add_step(OP_READ, 0, 24'h008040 + i, 0, 0, 1'b0, 0);
    add_step(OP_READ, 0, 24'h00FFEF, 0, 0, 1'b0, 0);
    add_step(OP_DONE, 0, 0, 0, 0, 0, 6);
  endtask

  initial begin
    step_t s;
    rst          = 1'b1;
    snes_addr    = '0;
    snes_data    = '0;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    pgm_valid    = 1'b0;
    pgm_idx      = '0;
    pgm_word     = '0;
    check_en     = 1'b0;
    exp_data     = '0;
    exp_ovr      = 1'b0;
    ready_chk_en = 1'b0;
    exp_ready    = 1'b1;
    test_done    = 1'b0;
    test_num     = '0;
    seed         = 32'h75d1bd94;
    table_ready  = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) next_cycle();

    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      case (s.op)
        OP_PGM:  host_program(s.idx, s.word);
        OP_CMD:  cmd_write(s.addr, s.data);
        OP_READ: bus_read(s.addr, 1'b1, s.data, s.ovr);
        OP_PEEK: bus_read(s.addr, 1'b0, 0, 1'b0);
        OP_IDLE: repeat (int'(s.n)) next_cycle();
        OP_CMD_PGM: begin
          fork
            cmd_write(s.addr, s.data);
            begin
              // Strobe is high three edges after wr_n rises
              repeat (7) next_cycle();
              host_program(s.idx, s.word);
            end
            begin
              // Ready drops for the strobe cycle only
              repeat (7) next_cycle();
              exp_ready    = 1'b0;
              ready_chk_en = 1'b1;
              next_cycle();
              exp_ready = 1'b1;
              next_cycle();
              ready_chk_en = 1'b0;
            end
          join
        end
        default: begin
          test_done = 1'b1;
          test_num  = s.n[3:0];
          next_cycle();
          test_done = 1'b0;
        end
      endcase
    end

    next_cycle();
    $display("Summary: %0d checks, %0d errors, %0d failed tests",
             check_count, error_count, fail_tests);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog scaled to the table length
  initial begin
    wait (table_ready);
    repeat (steps.size() * 2000) @(posedge clk);
    $display("Timeout: the stimulus table did not finish in %0d cycles", steps.size() * 2000);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
source/snes_bus_pkg.sv
source/patch_pkg.sv
source/bus_sync.sv
source/patch_table.sv
source/hook_ctrl.sv
source/snes_patch_top.sv
tb/patch_monitor.sv
tb/snes_patch_chk.sv
tb/snes_patch_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module snes_patch_tb -o snes_patch_sim

./obj_dir/snes_patch_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
